/* bank/bank_port_arb.sv */
// two-way arbiter in front of one memory bank
// a splitter lane and an outside contender share the bank; on a conflict the side
// that lost last time wins, a lone requester is granted in the same cycle
// the bank answers one cycle later and the response is sent back to its owner
`timescale 1ns/1ns
`default_nettype none

module bank_port_arb (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  split_pkg::narrow_req_t lane_req_i,
  output split_pkg::narrow_rsp_t lane_rsp_o,
  input  split_pkg::narrow_req_t ext_req_i,
  output split_pkg::narrow_rsp_t ext_rsp_o,
  output split_pkg::narrow_req_t mem_req_o,
  input  logic                   mem_rvalid_i,
  input  split_pkg::narrow_data_t mem_rdata_i
);

  import split_pkg::*;

  logic conflict;     // both sides want the bank
  logic lane_win;
  logic ext_win;
  logic ext_lost_q;   // 1 = contender lost the last conflict
  logic owner_ext_q;  // contender owned the bank last cycle

  assign conflict = lane_req_i.req & ext_req_i.req;

  // loser of the previous conflict goes first
  assign lane_win = lane_req_i.req & (~ext_req_i.req | ~ext_lost_q);
  assign ext_win  = ext_req_i.req & (~lane_req_i.req | ext_lost_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ext_lost_q <= 1'b0;           // lane first after reset
    end else if (conflict) begin
      ext_lost_q <= lane_win;       // flips on every conflict
    end
  end

  // remember the owner for the response cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_ext_q <= 1'b0;
    end else begin
      owner_ext_q <= ext_win;
    end
  end

  // winner to the bank; idle lane req is low so the default pick is harmless
  assign mem_req_o = ext_win ? ext_req_i : lane_req_i;

  assign lane_rsp_o = '{
    gnt:    lane_win,
    rvalid: mem_rvalid_i & ~owner_ext_q,
    rdata:  mem_rdata_i
  };

  assign ext_rsp_o = '{
    gnt:    ext_win,
    rvalid: mem_rvalid_i & owner_ext_q,
    rdata:  mem_rdata_i
  };

endmodule

`default_nettype wire

/* bank/bank_sram.sv */
// one narrow memory bank of BANK_WORDS words
// writes update only the enabled bytes, every accepted request answers with
// rvalid one cycle later; the word index comes from the lane byte address
`timescale 1ns/1ns
`default_nettype none

module bank_sram (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  split_pkg::narrow_req_t  mem_req_i,
  output logic                    rvalid_o,
  output split_pkg::narrow_data_t rdata_o
);

  import split_pkg::*;

  narrow_data_t mem_q [BANK_WORDS];
  bank_idx_t    idx;

  // skip the lane byte offset and the lane select bits
  assign idx = mem_req_i.addr[$clog2(N_CHAN*LANE_BYTES) +: $bits(bank_idx_t)];

  always_ff @(posedge clk_i) begin
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        for (int b = 0; b < LANE_BYTES; b++) begin
          if (mem_req_i.be[b]) begin
            mem_q[idx][b*8 +: 8] <= mem_req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];       // registered read
      end
    end
  end

  // one response per accepted request, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= mem_req_i.req;
    end
  end

endmodule

`default_nettype wire

/* common/split_pkg.sv */
// shared widths, vector types and port structs of the wide-to-narrow splitter
// every port uses the same req/gnt/rvalid handshake carried in these structs
// modules import this package inside their body and use scoped names in the port list
`default_nettype none

package split_pkg;

  localparam int unsigned WIDE_DW    = 64;                // wide accelerator port
  localparam int unsigned N_CHAN     = 2;                 // lanes = banks
  localparam int unsigned NARROW_DW  = WIDE_DW / N_CHAN;  // one lane word
  localparam int unsigned ADDR_W     = 32;                // byte address
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned LANE_BYTES = 4;                 // bytes per lane word

  typedef logic [ADDR_W-1:0]                addr_t;
  typedef logic [WIDE_DW-1:0]               wide_data_t;
  typedef logic [NARROW_DW-1:0]             narrow_data_t;
  typedef logic [N_CHAN*LANE_BYTES-1:0]     wide_be_t;
  typedef logic [LANE_BYTES-1:0]            narrow_be_t;
  typedef logic [$clog2(BANK_WORDS)-1:0]    bank_idx_t;  // word index inside one bank
  typedef logic [N_CHAN-1:0]                lane_mask_t; // one bit per lane

  // wide request, held stable by the requester until gnt
  typedef struct packed {
    logic       req;
    logic       we;     // 1 = store
    addr_t      addr;
    wide_be_t   be;
    wide_data_t wdata;
  } wide_req_t;

  typedef struct packed {
    logic       gnt;
    logic       rvalid; // one per accepted request, in order
    wide_data_t rdata;
  } wide_rsp_t;

  // lane / bank side request
  typedef struct packed {
    logic         req;
    logic         we;
    addr_t        addr;
    narrow_be_t   be;
    narrow_data_t wdata;
  } narrow_req_t;

  typedef struct packed {
    logic         gnt;
    logic         rvalid;
    narrow_data_t rdata;  // valid on reads only
  } narrow_rsp_t;

  // grant side: PASS forwards req to all lanes, HOLD re-requests the missing ones
  typedef enum logic {
    GNT_PASS,
    GNT_HOLD
  } gnt_state_e;

  // response side: WAIT while some lane words sit in the capture registers
  typedef enum logic {
    RSP_PASS,
    RSP_WAIT
  } rsp_state_e;

endpackage

`default_nettype wire

/* design/core_split.sv */
// splits one wide load/store into N_CHAN narrow lane requests
// wide gnt is raised once every lane has been granted, partial grants are remembered
// so only the missing lanes re-request; early lane responses are captured and merged
// into a single wide rvalid when the last lane answers
`timescale 1ns/1ns
`default_nettype none

module core_split (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  split_pkg::wide_req_t   wide_req_i,
  output split_pkg::wide_rsp_t   wide_rsp_o,
  output split_pkg::narrow_req_t lane_req_o [split_pkg::N_CHAN],
  input  split_pkg::narrow_rsp_t lane_rsp_i [split_pkg::N_CHAN]
);

  import split_pkg::*;

  gnt_state_e gnt_state_q, gnt_state_d;
  rsp_state_e rsp_state_q, rsp_state_d;

  lane_mask_t lane_gnt;                 // gnt from each lane this cycle
  lane_mask_t lane_rvalid;
  lane_mask_t gnt_mask_q, gnt_mask_d;   // lanes granted earlier in this request
  lane_mask_t hold_mask;                // mask seen only in HOLD
  lane_mask_t covered;                  // granted now or before
  logic       all_gnt;

  lane_mask_t                rsp_vld_q, rsp_vld_d;  // lane words already captured
  narrow_data_t [N_CHAN-1:0] rsp_data_q;            // early lane read data
  logic                      all_rsp;

  // lane handshake bits into vectors
  always_comb begin
    for (int n = 0; n < N_CHAN; n++) begin
      lane_gnt[n]    = lane_rsp_i[n].gnt;
      lane_rvalid[n] = lane_rsp_i[n].rvalid;
    end
  end

  assign hold_mask = (gnt_state_q == GNT_HOLD) ? gnt_mask_q : '0;
  assign covered   = lane_gnt | hold_mask;
  assign all_gnt   = wide_req_i.req & (&covered);

  // grant FSM
  always_comb begin
    gnt_state_d = gnt_state_q;
    gnt_mask_d  = gnt_mask_q;
    unique case (gnt_state_q)
      GNT_PASS: begin
        if (wide_req_i.req && !all_gnt) begin  // partly granted, remember who got through
          gnt_state_d = GNT_HOLD;
          gnt_mask_d  = lane_gnt;
        end
      end
      GNT_HOLD: begin
        if (all_gnt) begin
          gnt_state_d = GNT_PASS;
          gnt_mask_d  = '0;
        end else begin
          gnt_mask_d  = covered;               // accumulate late grants
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_state_q <= GNT_PASS;
      gnt_mask_q  <= '0;
    end else if (clear_i) begin
      gnt_state_q <= GNT_PASS;
      gnt_mask_q  <= '0;
    end else begin
      gnt_state_q <= gnt_state_d;
      gnt_mask_q  <= gnt_mask_d;
    end
  end

  // lane requests, granted lanes stay quiet until the wide gnt
  always_comb begin
    for (int n = 0; n < N_CHAN; n++) begin
      lane_req_o[n].req   = wide_req_i.req & ~hold_mask[n];
      lane_req_o[n].we    = wide_req_i.we;
      lane_req_o[n].addr  = wide_req_i.addr + addr_t'(n * LANE_BYTES);  // lane byte offset
      lane_req_o[n].be    = wide_req_i.be[n*LANE_BYTES +: LANE_BYTES];
      lane_req_o[n].wdata = wide_req_i.wdata[n*NARROW_DW +: NARROW_DW];
    end
  end

  // response FSM
  always_comb begin
    rsp_state_d = rsp_state_q;
    rsp_vld_d   = rsp_vld_q | lane_rvalid;
    all_rsp     = 1'b0;
    unique case (rsp_state_q)
      RSP_PASS: begin
        all_rsp = &lane_rvalid;               // all lanes answer together
        if (|lane_rvalid && !all_rsp) begin
          rsp_state_d = RSP_WAIT;
        end
      end
      RSP_WAIT: begin
        all_rsp = &(lane_rvalid | rsp_vld_q);
        if (all_rsp) begin
          rsp_state_d = RSP_PASS;
        end
      end
    endcase
    if (all_rsp) begin
      rsp_vld_d = '0;                         // transaction done, flags free for the next one
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_state_q <= RSP_PASS;
      rsp_vld_q   <= '0;
    end else if (clear_i) begin
      rsp_state_q <= RSP_PASS;
      rsp_vld_q   <= '0;
    end else begin
      rsp_state_q <= rsp_state_d;
      rsp_vld_q   <= rsp_vld_d;
    end
  end

  // capture lane read data as it arrives
  always_ff @(posedge clk_i) begin
    for (int n = 0; n < N_CHAN; n++) begin
      if (lane_rvalid[n]) begin
        rsp_data_q[n] <= lane_rsp_i[n].rdata;
      end
    end
  end

  // merged wide response
  always_comb begin
    wide_rsp_o.gnt    = all_gnt;
    wide_rsp_o.rvalid = all_rsp;
    for (int n = 0; n < N_CHAN; n++) begin
      // captured word for early lanes, live data for the late ones
      wide_rsp_o.rdata[n*NARROW_DW +: NARROW_DW] =
        (rsp_state_q == RSP_WAIT && rsp_vld_q[n]) ? rsp_data_q[n] : lane_rsp_i[n].rdata;
    end
  end

endmodule

`default_nettype wire

/* design/split_top.sv */
// top level of the splitter subsystem
// wide port -> core_split -> one arbiter and one bank per lane
// each bank also exposes an outside contender port; no added latency
`timescale 1ns/1ns
`default_nettype none

module split_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  split_pkg::wide_req_t   wide_req_i,
  output split_pkg::wide_rsp_t   wide_rsp_o,
  input  split_pkg::narrow_req_t ext_req_i [split_pkg::N_CHAN],
  output split_pkg::narrow_rsp_t ext_rsp_o [split_pkg::N_CHAN]
);

  import split_pkg::*;

  narrow_req_t  lane_req  [N_CHAN];  // splitter -> arbiter
  narrow_rsp_t  lane_rsp  [N_CHAN];  // arbiter -> splitter
  narrow_req_t  mem_req   [N_CHAN];  // arbiter -> bank
  lane_mask_t   mem_rvalid;
  narrow_data_t mem_rdata [N_CHAN];

  core_split u_split (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .wide_req_i (wide_req_i),
    .wide_rsp_o (wide_rsp_o),
    .lane_req_o (lane_req),
    .lane_rsp_i (lane_rsp)
  );

  for (genvar n = 0; n < N_CHAN; n++) begin : g_bank

    // lane n vs contender n
    bank_port_arb u_arb (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .lane_req_i   (lane_req[n]),
      .lane_rsp_o   (lane_rsp[n]),
      .ext_req_i    (ext_req_i[n]),
      .ext_rsp_o    (ext_rsp_o[n]),
      .mem_req_o    (mem_req[n]),
      .mem_rvalid_i (mem_rvalid[n]),
      .mem_rdata_i  (mem_rdata[n])
    );

    // bank n holds lane n of every wide word
    bank_sram u_sram (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .mem_req_i (mem_req[n]),
      .rvalid_o  (mem_rvalid[n]),
      .rdata_o   (mem_rdata[n])
    );

  end

endmodule

`default_nettype wire

/* project.f */
common/split_pkg.sv
bank/bank_sram.sv
bank/bank_port_arb.sv
design/core_split.sv
design/split_top.sv
sim/tb_clock.sv
sim/split_asserts.sv
sim/tb_split.sv

/* sim/split_asserts.sv */
// protocol checks on the splitter, attached to every core_split by bind
// wide payload held until gnt, no wide rvalid without an outstanding gnt,
// and a lane keeps its req up until that lane is granted
`timescale 1ns/1ns
`default_nettype none

module split_asserts (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   clear_i,
  input split_pkg::wide_req_t   wide_req_i,
  input split_pkg::wide_rsp_t   wide_rsp_i,
  input split_pkg::narrow_req_t lane_req_i [split_pkg::N_CHAN],
  input split_pkg::narrow_rsp_t lane_rsp_i [split_pkg::N_CHAN]
);

  import split_pkg::*;

  int unsigned outstanding_q;  // accepted wide requests still waiting for rvalid

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 0;
    end else if (clear_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + (wide_req_i.req & wide_rsp_i.gnt) - wide_rsp_i.rvalid;
    end
  end

  a_wide_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    wide_req_i.req && !wide_rsp_i.gnt |=> wide_req_i.req && $stable(wide_req_i))
    else $error("wide request changed before its gnt");

  a_rvalid_owed: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    wide_rsp_i.rvalid |-> outstanding_q != 0)
    else $error("wide rvalid without an accepted request");

  for (genvar n = 0; n < N_CHAN; n++) begin : g_lane
    a_lane_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      lane_req_i[n].req && !lane_rsp_i[n].gnt |=> lane_req_i[n].req)
      else $error("lane %0d dropped req before its gnt", n);
  end

endmodule

bind core_split split_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .clear_i    (clear_i),
  .wide_req_i (wide_req_i),
  .wide_rsp_i (wide_rsp_o),
  .lane_req_i (lane_req_o),
  .lane_rsp_i (lane_rsp_i)
);

`default_nettype wire

/* sim/tb_clock.sv */
// clock and reset source for the splitter testbench
// 4 ns clock, active-low reset held for the first 16 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD  = 2;   // 4 ns period
  localparam int RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;                  // release on an edge, like the stimulus
  end

endmodule

`default_nettype wire

/* sim/tb_split.sv */
// directed testbench for the splitter subsystem
// drives the wide port and both contender ports, predicts read data from a
// reference memory of wide words and checks grant timing and response order
`timescale 1ns/1ns
`default_nettype none

module tb_split;

  import split_pkg::*;

  localparam int N_BYTE = 12;  // byte-enable write/read pairs
  localparam int N_RAND = 32;  // reads under random contention
  // reset, fill, basic, byte enables, contention, contender port, random, clear
  localparam int TEST_CYCLES    = 16 + 264 + 16 + 32 + 40 + 168 + N_RAND * 4 + 8 + 20;
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

  logic        clk, rst_n, clear;
  wide_req_t   wide_req;
  wide_rsp_t   wide_rsp;
  narrow_req_t ext_req [N_CHAN];
  narrow_rsp_t ext_rsp [N_CHAN];

  wide_data_t ref_mem [BANK_WORDS];  // expected contents, one entry per wide word
  wide_data_t exp_q [$];             // expected data per accepted wide request
  logic       exp_rd_q [$];          // 1 = read, data gets compared
  wide_data_t got_q [$];             // rdata seen at each wide rvalid
  int         gnt_cnt = 0;
  int         rvalid_cnt = 0;
  int         cycle_cnt = 0;
  int         checks = 0;
  int         errors = 0;
  logic       excl_on = 1'b0;        // one bank contended, grants predicted per cycle
  int         excl_lane = 0;
  logic [N_CHAN-1:0] ext_lost_ref = '0;  // expected last loser per arbiter, lane first
  logic       reads_done = 1'b0;

  tb_clock u_clock (.clk_o(clk), .rst_no(rst_n));

  split_top UUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .clear_i    (clear),
    .wide_req_i (wide_req),
    .wide_rsp_o (wide_rsp),
    .ext_req_i  (ext_req),
    .ext_rsp_o  (ext_rsp)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, %0d errors so far", cycle_cnt, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_equal(input logic [63:0] expected, input logic [63:0] actual,
                             input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s, expected %h, got %h", $time, msg, expected, actual);
    end
  endtask

  // outputs are stable half a cycle after the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (wide_req.req && wide_rsp.gnt) gnt_cnt++;
      if (wide_rsp.rvalid) begin
        rvalid_cnt++;
        got_q.push_back(wide_rsp.rdata);
      end
      // lane and contender both asking, the last loser wins
      if (excl_on && wide_req.req && ext_req[excl_lane].req) begin
        check_equal(!ext_lost_ref[excl_lane], wide_rsp.gnt, "wide gnt under contention");
        check_equal(ext_lost_ref[excl_lane], ext_rsp[excl_lane].gnt,
                    "contender gnt under contention");
        ext_lost_ref[excl_lane] = !ext_lost_ref[excl_lane];  // priority flips
      end
    end
  end

  function automatic wide_data_t merge_bytes(wide_data_t old_d, wide_data_t new_d, wide_be_t be);
    wide_data_t res;
    res = old_d;
    for (int b = 0; b < $bits(wide_be_t); b++) begin
      if (be[b]) res[b*8 +: 8] = new_d[b*8 +: 8];
    end
    return res;
  endfunction

  // present one wide request and hold it until gnt, req stays up afterwards
  task automatic wide_issue(input logic we, input addr_t addr, input wide_be_t be,
                            input wide_data_t wdata, output int waited);
    logic      granted;
    bank_idx_t idx;
    granted = 1'b0;
    waited  = 0;
    idx     = addr[10:3];           // wide word index
    @(posedge clk);
    wide_req <= '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
    while (!granted) begin
      @(negedge clk);
      if (wide_rsp.gnt) begin
        granted = 1'b1;
      end else begin
        waited++;
        @(posedge clk);             // keep holding
      end
    end
    if (we) ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
    exp_q.push_back(ref_mem[idx]);
    exp_rd_q.push_back(!we);
  endtask

  task automatic wide_idle();
    @(posedge clk);
    wide_req <= '0;
  endtask

  // single full-word access on a contender port, returns read data at rvalid
  task automatic ext_access(input int c, input logic we, input bank_idx_t idx,
                            input narrow_data_t wdata, output narrow_data_t rdata);
    @(posedge clk);
    ext_req[c] <= '{req: 1'b1, we: we, addr: (addr_t'(idx) << 3) + addr_t'(c * LANE_BYTES),
                    be: '1, wdata: wdata};
    do @(negedge clk); while (!ext_rsp[c].gnt);
    @(posedge clk);
    ext_req[c] <= '0;
    do @(negedge clk); while (!ext_rsp[c].rvalid);
    rdata = ext_rsp[c].rdata;
  endtask

  // wait for all owed responses, then compare them in order
  task automatic drain_responses(input string tag);
    wide_data_t got;
    while (got_q.size() < exp_q.size()) @(negedge clk);
    repeat (4) @(negedge clk);      // room for a duplicate rvalid to show up
    check_equal(exp_q.size(), got_q.size(), {tag, ": response count"});
    check_equal(gnt_cnt, rvalid_cnt, {tag, ": gnt count vs rvalid count"});
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      got = got_q.pop_front();
      if (exp_rd_q.pop_front()) check_equal(exp_q.pop_front(), got, {tag, ": read data"});
      else void'(exp_q.pop_front());
    end
    exp_q.delete();
    exp_rd_q.delete();
    got_q.delete();
  endtask

  task automatic fill_memory();
    int w;
    for (int i = 0; i < BANK_WORDS; i++) begin
      wide_issue(1'b1, addr_t'(i) << 3, '1, {4{8'(i), ~8'(i)}}, w);
    end
    wide_idle();
    drain_responses("fill");
  endtask

  task automatic basic_write_read(input bank_idx_t idx, input wide_data_t data,
                                  input string tag);
    int w;
    wide_issue(1'b1, addr_t'(idx) << 3, '1, data, w);
    check_equal(0, w, {tag, ": write gnt in request cycle"});
    wide_idle();
    @(negedge clk);
    check_equal(1, wide_rsp.rvalid, {tag, ": write rvalid one cycle after gnt"});
    wide_issue(1'b0, addr_t'(idx) << 3, '0, '0, w);
    check_equal(0, w, {tag, ": read gnt in request cycle"});
    wide_idle();
    @(negedge clk);
    check_equal(1, wide_rsp.rvalid, {tag, ": read rvalid one cycle after gnt"});
    check_equal(data, wide_rsp.rdata, {tag, ": read returns written word"});
    drain_responses(tag);
  endtask

  task automatic byte_enable_writes();
    int        w;
    bank_idx_t idx;
    for (int i = 0; i < N_BYTE; i++) begin
      idx = bank_idx_t'($urandom);
      wide_issue(1'b1, addr_t'(idx) << 3, wide_be_t'($urandom), {$urandom, $urandom}, w);
      wide_issue(1'b0, addr_t'(idx) << 3, '0, '0, w);  // read back at once
    end
    wide_idle();
    drain_responses("byte enables");
  endtask

  task automatic hold_contender(input int c, input int cycles);
    @(posedge clk);
    ext_req[c] <= '{req: 1'b1, we: 1'b0, addr: addr_t'(c * LANE_BYTES), be: '0, wdata: '0};
    repeat (cycles) @(posedge clk);
    ext_req[c] <= '0;
  endtask

  task automatic contended_reads();
    int w;
    int waited_sum;
    for (int c = 0; c < N_CHAN; c++) begin
      waited_sum = 0;
      excl_lane  = c;
      excl_on    = 1'b1;
      fork
        hold_contender(c, 10);
        begin
          @(posedge clk);           // contender gets the bank one cycle ahead
          for (int i = 0; i < 3; i++) begin
            wide_issue(1'b0, addr_t'($urandom % BANK_WORDS) << 3, '0, '0, w);
            waited_sum += w;
          end
          wide_idle();
        end
      join
      excl_on = 1'b0;
      check_equal(1, waited_sum > 0, "contention delays the wide gnt");
      drain_responses("contention");
    end
  endtask

  task automatic contender_port_access();
    int           w;
    bank_idx_t    idx;
    narrow_data_t data;
    narrow_data_t rd;
    wide_data_t   wdata;
    for (int c = 0; c < N_CHAN; c++) begin
      for (int i = 0; i < 3; i++) begin
        idx  = bank_idx_t'($urandom);
        data = $urandom;
        ext_access(c, 1'b1, idx, data, rd);
        ref_mem[idx][c*NARROW_DW +: NARROW_DW] = data;  // lane c half of the wide word
        wide_issue(1'b0, addr_t'(idx) << 3, '0, '0, w);
        wide_idle();
        drain_responses("contender write, wide read");
        idx   = bank_idx_t'($urandom);
        wdata = {$urandom, $urandom};
        wide_issue(1'b1, addr_t'(idx) << 3, '1, wdata, w);
        wide_idle();
        drain_responses("wide write");
        ext_access(c, 1'b0, idx, '0, rd);
        check_equal(wdata[c*NARROW_DW +: NARROW_DW], rd, "contender read of wide data");
      end
    end
  endtask

  // random read traffic on both contender ports, each request held until gnt
  task automatic random_contenders();
    logic [N_CHAN-1:0] granted;
    granted = '1;
    while (!reads_done) begin
      @(posedge clk);
      for (int c = 0; c < N_CHAN; c++) begin
        if (!ext_req[c].req || granted[c]) begin
          ext_req[c] <= '{req: ($urandom % 2 == 0), we: 1'b0, addr: addr_t'($urandom),
                          be: '0, wdata: '0};
        end
      end
      @(negedge clk);
      for (int c = 0; c < N_CHAN; c++) granted[c] = ext_rsp[c].gnt;
    end
    @(posedge clk);
    for (int c = 0; c < N_CHAN; c++) ext_req[c] <= '0;
  endtask

  task automatic random_contention_reads();
    int w;
    reads_done = 1'b0;
    fork
      begin
        for (int i = 0; i < N_RAND; i++) begin
          wide_issue(1'b0, addr_t'($urandom % BANK_WORDS) << 3, '0, '0, w);
        end
        wide_idle();
        reads_done = 1'b1;
      end
      random_contenders();
    join
    drain_responses("random contention");
  endtask

  task automatic clear_while_idle();
    @(posedge clk);
    clear <= 1'b1;
    @(negedge clk);
    check_equal(0, {wide_rsp.gnt, wide_rsp.rvalid}, "gnt and rvalid during clear");
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    check_equal(0, {wide_rsp.gnt, wide_rsp.rvalid}, "gnt and rvalid after clear");
    basic_write_read(bank_idx_t'($urandom), {$urandom, $urandom}, "after clear");
  endtask

  initial begin
    void'($urandom(64700));
    clear    = 1'b0;
    wide_req = '0;
    for (int c = 0; c < N_CHAN; c++) ext_req[c] = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    fill_memory();
    basic_write_read(8'h11, 64'h0123_4567_89ab_cdef, "basic");
    byte_enable_writes();
    contended_reads();
    contender_port_access();
    random_contention_reads();
    clear_while_idle();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
